// File: compile.f
+incdir+include
logic/rf_pkg.sv
logic/rf_mem_2r1w.sv
logic/rf_write_arbiter.sv
logic/rf_load_port.sv
logic/rf_alu_port.sv
logic/rf_top.sv
tests/rf_tb.sv

// File: logic/rf_alu_port.sv
`timescale 1ns/1ps
`default_nettype none

module rf_alu_port
(
   input  wire                w_clk_i,
   input  wire                rst_n_i,

   input  wire                op_v_i,
   input  rf_pkg::alu_op_e    op_i,
   input  rf_pkg::rf_addr_t   rd_i,
   input  rf_pkg::rf_addr_t   rs1_i,
   input  rf_pkg::rf_addr_t   rs2_i,

   output rf_pkg::rf_addr_t   r0_addr_o,
   output rf_pkg::rf_addr_t   r1_addr_o,
   input  rf_pkg::rf_data_t   r0_data_i,
   input  rf_pkg::rf_data_t   r1_data_i,

   input  wire                gnt_i,
   output logic               req_o,
   output rf_pkg::rf_addr_t   addr_o,
   output rf_pkg::rf_data_t   data_o,

   output logic               result_v_o,
   output rf_pkg::rf_data_t   result_o
);

   import rf_pkg::*;

   rf_data_t alu_res;
   rf_data_t res_q;
   rf_addr_t rd_q;

   assign r0_addr_o = rs1_i;
   assign r1_addr_o = rs2_i;

   always_comb
   begin
      case (op_i)
         OP_ADD:  alu_res = r0_data_i + r1_data_i;   // add wraps at 16 bits
         OP_SUB:  alu_res = r0_data_i - r1_data_i;
         OP_AND:  alu_res = r0_data_i & r1_data_i;
         OP_XOR:  alu_res = r0_data_i ^ r1_data_i;
         default: alu_res = r0_data_i + r1_data_i;
      endcase
   end

   always_ff @(posedge w_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         req_o      <= 1'b0;
         result_v_o <= 1'b0;
      end
      else
      begin
         result_v_o <= op_v_i;           // one-cycle pulse
         if (op_v_i)
         begin
            req_o <= 1'b1;
         end
         else if (gnt_i)
         begin
            req_o <= 1'b0;
         end
      end
   end

   // result doubles as pending write data
   always_ff @(posedge w_clk_i)
   begin
      if (op_v_i)
      begin
         res_q <= alu_res;
         rd_q  <= rd_i;
      end
   end

   assign addr_o   = rd_q;
   assign data_o   = res_q;
   assign result_o = res_q;

endmodule

`default_nettype wire

// File: logic/rf_load_port.sv
`timescale 1ns/1ps
`default_nettype none

module rf_load_port
(
   input  wire                w_clk_i,
   input  wire                rst_n_i,

   input  wire                load_v_i,
   input  rf_pkg::rf_addr_t   load_addr_i,
   input  rf_pkg::rf_data_t   load_data_i,

   input  wire                gnt_i,
   output logic               req_o,
   output rf_pkg::rf_addr_t   addr_o,
   output rf_pkg::rf_data_t   data_o
);

   import rf_pkg::*;

   rf_addr_t addr_q;
   rf_data_t data_q;

   always_ff @(posedge w_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         req_o <= 1'b0;
      end
      else if (load_v_i)
      begin
         req_o <= 1'b1;
      end
      else if (gnt_i)
      begin
         req_o <= 1'b0;                  // write lands this edge
      end
   end

   always_ff @(posedge w_clk_i)
   begin
      if (load_v_i)
      begin
         addr_q <= load_addr_i;
         data_q <= load_data_i;
      end
   end

   assign addr_o = addr_q;
   assign data_o = data_q;

endmodule

`default_nettype wire

// File: logic/rf_mem_2r1w.sv
`timescale 1ns/1ps
`default_nettype none

module rf_mem_2r1w
(
   input  wire                w_clk_i,
   input  wire                rst_n_i,

   input  wire                w_v_i,
   input  rf_pkg::rf_addr_t   w_addr_i,
   input  rf_pkg::rf_data_t   w_data_i,

   input  rf_pkg::rf_addr_t   r0_addr_i,
   output rf_pkg::rf_data_t   r0_data_o,

   input  rf_pkg::rf_addr_t   r1_addr_i,
   output rf_pkg::rf_data_t   r1_data_o
);

   import rf_pkg::*;

   rf_data_t mem_q [RF_ELS];

   always_ff @(posedge w_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < RF_ELS; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (w_v_i)
      begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // no bypass, same-cycle write shows next cycle
   assign r0_data_o = mem_q[r0_addr_i];
   assign r1_data_o = mem_q[r1_addr_i];

endmodule

`default_nettype wire

// File: logic/rf_pkg.sv
`default_nettype none

package rf_pkg;

   localparam int RF_ELS = 16;            // register count

   typedef logic [15:0] rf_data_t;        // one register word
   typedef logic [3:0]  rf_addr_t;        // register index

   // host opcodes for the alu port
   typedef enum logic [1:0]
   {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_AND = 2'd2,
      OP_XOR = 2'd3
   } alu_op_e;

   // last peer that won the write port
   typedef enum logic
   {
      OWN_LOAD = 1'b0,
      OWN_ALU  = 1'b1
   } wr_owner_e;

endpackage

`default_nettype wire

// File: logic/rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module rf_top
(
   input  wire                w_clk_i,
   input  wire                rst_n_i,

   input  wire                load_v_i,
   input  rf_pkg::rf_addr_t   load_addr_i,
   input  rf_pkg::rf_data_t   load_data_i,

   input  wire                op_v_i,
   input  rf_pkg::alu_op_e    op_i,
   input  rf_pkg::rf_addr_t   rd_i,
   input  rf_pkg::rf_addr_t   rs1_i,
   input  rf_pkg::rf_addr_t   rs2_i,

   output logic               busy_o,
   output logic               result_v_o,
   output rf_pkg::rf_data_t   result_o
);

   import rf_pkg::*;

   logic     load_req, load_gnt;
   rf_addr_t load_addr;
   rf_data_t load_data;

   logic     alu_req, alu_gnt;
   rf_addr_t alu_addr;
   rf_data_t alu_data;

   logic     w_v;
   rf_addr_t w_addr;
   rf_data_t w_data;

   rf_addr_t r0_addr, r1_addr;
   rf_data_t r0_data, r1_data;

   rf_mem_2r1w u_mem
   (
      .w_clk_i    (w_clk_i),
      .rst_n_i    (rst_n_i),
      .w_v_i      (w_v),
      .w_addr_i   (w_addr),
      .w_data_i   (w_data),
      .r0_addr_i  (r0_addr),
      .r0_data_o  (r0_data),
      .r1_addr_i  (r1_addr),
      .r1_data_o  (r1_data)
   );

   rf_write_arbiter u_arb
   (
      .w_clk_i     (w_clk_i),
      .rst_n_i     (rst_n_i),
      .load_req_i  (load_req),
      .load_addr_i (load_addr),
      .load_data_i (load_data),
      .alu_req_i   (alu_req),
      .alu_addr_i  (alu_addr),
      .alu_data_i  (alu_data),
      .load_gnt_o  (load_gnt),
      .alu_gnt_o   (alu_gnt),
      .w_v_o       (w_v),
      .w_addr_o    (w_addr),
      .w_data_o    (w_data)
   );

   rf_load_port u_load
   (
      .w_clk_i     (w_clk_i),
      .rst_n_i     (rst_n_i),
      .load_v_i    (load_v_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .gnt_i       (load_gnt),
      .req_o       (load_req),
      .addr_o      (load_addr),
      .data_o      (load_data)
   );

   rf_alu_port u_alu
   (
      .w_clk_i     (w_clk_i),
      .rst_n_i     (rst_n_i),
      .op_v_i      (op_v_i),
      .op_i        (op_i),
      .rd_i        (rd_i),
      .rs1_i       (rs1_i),
      .rs2_i       (rs2_i),
      .r0_addr_o   (r0_addr),
      .r1_addr_o   (r1_addr),
      .r0_data_i   (r0_data),
      .r1_data_i   (r1_data),
      .gnt_i       (alu_gnt),
      .req_o       (alu_req),
      .addr_o      (alu_addr),
      .data_o      (alu_data),
      .result_v_o  (result_v_o),
      .result_o    (result_o)
   );

   assign busy_o = load_req | alu_req;   // any write still pending

endmodule

`default_nettype wire

// File: logic/rf_write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rf_write_arbiter
(
   input  wire                w_clk_i,
   input  wire                rst_n_i,

   input  wire                load_req_i,
   input  rf_pkg::rf_addr_t   load_addr_i,
   input  rf_pkg::rf_data_t   load_data_i,

   input  wire                alu_req_i,
   input  rf_pkg::rf_addr_t   alu_addr_i,
   input  rf_pkg::rf_data_t   alu_data_i,

   output logic               load_gnt_o,
   output logic               alu_gnt_o,

   output logic               w_v_o,
   output rf_pkg::rf_addr_t   w_addr_o,
   output rf_pkg::rf_data_t   w_data_o
);

   import rf_pkg::*;

   wr_owner_e last_q;

   // a tie goes to whoever did not win last
   assign load_gnt_o = load_req_i & (~alu_req_i | (last_q == OWN_ALU));
   assign alu_gnt_o  = alu_req_i & (~load_req_i | (last_q == OWN_LOAD));

   assign w_v_o    = load_gnt_o | alu_gnt_o;
   assign w_addr_o = alu_gnt_o ? alu_addr_i : load_addr_i;
   assign w_data_o = alu_gnt_o ? alu_data_i : load_data_i;

   always_ff @(posedge w_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         last_q <= OWN_ALU;              // load wins first tie
      end
      else if (load_gnt_o)
      begin
         last_q <= OWN_LOAD;
      end
      else if (alu_gnt_o)
      begin
         last_q <= OWN_ALU;
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the register-file testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module rf_tb --Mdir obj_dir -o rf_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/rf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
   exit 1
fi
exit 0

// File: include/rf_tb_util.svh
`ifndef RF_TB_UTIL_SVH
`define RF_TB_UTIL_SVH

// numerical recipes lcg step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// expected alu result, wraps like the hardware
function automatic rf_pkg::rf_data_t ref_alu
(
   input rf_pkg::alu_op_e  op,
   input rf_pkg::rf_data_t a,
   input rf_pkg::rf_data_t b
);
   case (op)
      rf_pkg::OP_ADD: return a + b;
      rf_pkg::OP_SUB: return a - b;
      rf_pkg::OP_AND: return a & b;
      rf_pkg::OP_XOR: return a ^ b;
      default:        return a + b;
   endcase
endfunction

// compare one value, count and report a mismatch
task automatic check_val
(
   input string            tag,
   input rf_pkg::rf_data_t got,
   input rf_pkg::rf_data_t exp,
   inout int               errors
);
   if (got !== exp)
   begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, tag, got, exp);
   end
endtask

`endif

// File: tests/rf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_tb;

   import rf_pkg::*;

   `include "rf_tb_util.svh"

   localparam int N_LOAD  = 20;
   localparam int N_OPS   = 40;
   localparam int N_TIE   = 8;
   localparam int N_ALIAS = 4;
   localparam int N_MIX   = 200;
   localparam int TOTAL_CMDS = RF_ELS * RF_ELS + 2 * N_LOAD + 5 + 2 * N_OPS
                               + 4 * N_TIE + 2 * N_ALIAS + N_MIX;
   localparam int WATCHDOG_NS = (TOTAL_CMDS * 10 + 200) * 40;

   logic     w_clk;
   logic     rst_n;
   logic     load_v;
   rf_addr_t load_addr;
   rf_data_t load_data;
   logic     op_v;
   alu_op_e  op;
   rf_addr_t rd, rs1, rs2;
   logic     busy, result_v;
   rf_data_t result;

   rf_data_t    shadow [RF_ELS];           // expected register contents
   rf_data_t    exp_q [$];                 // results still to come
   logic [31:0] rng_state;
   logic        load_won_last;             // arbiter history
   int          errors, n_cmds, n_ops, n_results;

   rf_top u_rf_top
   (
      .w_clk_i     (w_clk),
      .rst_n_i     (rst_n),
      .load_v_i    (load_v),
      .load_addr_i (load_addr),
      .load_data_i (load_data),
      .op_v_i      (op_v),
      .op_i        (op),
      .rd_i        (rd),
      .rs1_i       (rs1),
      .rs2_i       (rs2),
      .busy_o      (busy),
      .result_v_o  (result_v),
      .result_o    (result)
   );

   initial
   begin
      w_clk = 1'b0;
      forever #20 w_clk = ~w_clk;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("%0t ns: timeout, tests still running after %0d ns", $time, WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   // outputs are settled by the falling edge
   always @(negedge w_clk)
   begin
      if (rst_n && result_v)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("%0t ns: result_v_o pulsed with no op outstanding", $time);
         end
         else
         begin
            check_val("alu result", result, exp_q.pop_front(), errors);
            n_results++;
         end
      end
   end

   function automatic logic [31:0] rand_word();
      rng_state = lcg_next(rng_state);
      return rng_state;
   endfunction

   function automatic rf_addr_t rand_addr();
      logic [31:0] w;
      w = rand_word();
      return w[31:28];
   endfunction

   function automatic rf_data_t rand_data();
      logic [31:0] w;
      w = rand_word();
      return w[31:16];
   endfunction

   function automatic alu_op_e rand_op();
      logic [31:0] w;
      w = rand_word();
      return alu_op_e'(w[31:30]);
   endfunction

   // one host command, then wait for the writes to drain
   task automatic issue_cmd
   (
      input logic     do_load,
      input rf_addr_t la,
      input rf_data_t ld,
      input logic     do_op,
      input alu_op_e  o,
      input rf_addr_t d,
      input rf_addr_t s1,
      input rf_addr_t s2
   );
      rf_data_t res;
      logic     tie;
      logic     load_first;
      int       busy_cycles;
      res = ref_alu(o, shadow[s1], shadow[s2]);   // values before any write
      tie = do_load & do_op;
      load_first = do_load & (~do_op | ~load_won_last);
      if (do_op)
         exp_q.push_back(res);
      @(posedge w_clk);
      load_v    <= do_load;
      load_addr <= la;
      load_data <= ld;
      op_v      <= do_op;
      op        <= o;
      rd        <= d;
      rs1       <= s1;
      rs2       <= s2;
      @(posedge w_clk);
      load_v <= 1'b0;
      op_v   <= 1'b0;
      @(negedge w_clk);
      if (result_v !== do_op)
      begin
         errors++;
         $display("%0t ns: result_v_o does not follow the command in the next cycle", $time);
      end
      if (u_rf_top.load_gnt !== load_first || u_rf_top.alu_gnt !== (do_op & ~load_first))
      begin
         errors++;
         $display("%0t ns: write port granted to the wrong peer", $time);
      end
      busy_cycles = 0;
      while (busy === 1'b1 && busy_cycles < 8)
      begin
         busy_cycles++;
         @(negedge w_clk);
      end
      if (busy_cycles >= 8)
      begin
         errors++;
         $display("%0t ns: busy_o stuck high after a command", $time);
      end
      else
         check_val("busy cycles", rf_data_t'(busy_cycles), tie ? 16'd2 : 16'd1, errors);
      if (do_load)
         shadow[la] = ld;
      if (do_op)
         shadow[d] = res;
      load_won_last = tie ? ~load_first : do_load;   // tie loser wins last
      n_cmds++;
      if (do_op)
         n_ops++;
   endtask

   task automatic do_load_only(input rf_addr_t a, input rf_data_t v);
      issue_cmd(1'b1, a, v, 1'b0, OP_ADD, '0, '0, '0);
   endtask

   task automatic do_op_only(input alu_op_e o, input rf_addr_t d, input rf_addr_t s1,
                             input rf_addr_t s2);
      issue_cmd(1'b0, '0, '0, 1'b1, o, d, s1, s2);
   endtask

   task automatic report_test(input int num, input string name, input int base);
      $display("test %0d %s finished with %0d errors", num, name, errors - base);
   endtask

   initial
   begin
      int       base;
      rf_addr_t a, b, d;
      rf_data_t v;
      logic [31:0] w;
      rst_n = 1'b0;
      load_v = 1'b0;
      load_addr = '0;
      load_data = '0;
      op_v = 1'b0;
      op = OP_ADD;
      rd = '0;
      rs1 = '0;
      rs2 = '0;
      rng_state = 32'h5665_512f;
      load_won_last = 1'b0;                  // reset makes the alu the last winner
      errors = 0;
      n_cmds = 0;
      n_ops = 0;
      n_results = 0;
      for (int i = 0; i < RF_ELS; i++)
         shadow[i] = '0;
      repeat (4) @(posedge w_clk);
      rst_n <= 1'b1;
      @(negedge w_clk);

      base = errors;
      check_val("busy after reset", {15'd0, busy}, 16'd0, errors);
      check_val("result_v after reset", {15'd0, result_v}, 16'd0, errors);
      for (int i = 0; i < RF_ELS; i++)
         for (int j = 0; j < RF_ELS; j++)
            do_op_only(OP_ADD, rf_addr_t'(i), rf_addr_t'(i), rf_addr_t'(j));
      report_test(1, "reset state", base);

      base = errors;
      for (int i = 0; i < N_LOAD; i++)
      begin
         a = rand_addr();
         if (a == 0)
            a = 4'd1;                        // r0 stays zero here
         do_load_only(a, rand_data());
         do_op_only(OP_ADD, a, a, 4'd0);
      end
      report_test(2, "loads and readback", base);

      base = errors;
      do_load_only(4'd1, 16'hffff);
      do_load_only(4'd2, 16'h0002);
      do_op_only(OP_ADD, 4'd3, 4'd1, 4'd2);  // wraps to 1
      do_op_only(OP_SUB, 4'd4, 4'd2, 4'd1);  // wraps to 3
      do_op_only(OP_XOR, 4'd5, 4'd3, 4'd4);
      d = 4'd5;
      for (int i = 0; i < N_OPS; i++)
      begin
         a = rand_addr();
         do_load_only(a, rand_data());
         b = d;
         d = rand_addr();
         do_op_only(rand_op(), d, a, b);     // reads the previous rd
      end
      report_test(3, "all opcodes", base);

      base = errors;
      for (int i = 0; i < N_TIE; i++)
      begin
         a = rand_addr();
         d = rand_addr();
         if (d == a)
            d = a + 4'd1;
         if (i % 2 == 1)
            do_load_only(a, rand_data());    // flips the next tie winner
         v = rand_data();
         issue_cmd(1'b1, a, v, 1'b1, rand_op(), d, a, d);
         do_op_only(OP_AND, a, a, a);
         do_op_only(OP_AND, d, d, d);
      end
      report_test(4, "load and op together", base);

      base = errors;
      for (int i = 0; i < N_ALIAS; i++)
      begin
         a = rand_addr();
         b = (i % 2 == 1) ? a : rand_addr();
         do_op_only(rand_op(), a, a, b);
         do_op_only(OP_AND, a, a, a);
      end
      report_test(5, "aliased registers", base);

      base = errors;
      for (int i = 0; i < N_MIX; i++)
      begin
         w = rand_word();
         a = rand_addr();
         d = rand_addr();
         if (w[31:30] == 2'd0)
            do_load_only(a, rand_data());
         else if (w[31:30] == 2'd3)
         begin
            if (d == a)
               d = a ^ 4'd8;
            issue_cmd(1'b1, a, rand_data(), 1'b1, rand_op(), d, rand_addr(), rand_addr());
         end
         else
            do_op_only(rand_op(), d, a, rand_addr());
      end
      report_test(6, "random mixed stream", base);

      if (exp_q.size() != 0 || n_results != n_ops)
      begin
         errors++;
         $display("%0t ns: %0d ops issued but %0d results seen", $time, n_ops, n_results);
      end
      $display("summary: %0d commands, %0d results checked, %0d errors",
               n_cmds, n_results, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire
